//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP      = heapTb
FILELIST = list.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) +verilator+error+limit+100 2>&1 | tee $(LOG)
	grep -qFx '** PASS **' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- include/heap_defines.svh
//----------------------------------------
// Heap widths and Modify sub-operation codes
//----------------------------------------
`ifndef HEAP_DEFINES_SVH
`define HEAP_DEFINES_SVH

// ---------------------------------------
// Widths
// ---------------------------------------
`define HEAP_ADDRESS_BITS 3                   // 8 arrays
`define HEAP_INDEX_BITS   3                   // 8 elements per array
`define HEAP_DATA_BITS    12                  // Element width

`define HEAP_ARRAYS       (1 << `HEAP_ADDRESS_BITS)
`define HEAP_ARRAY_LENGTH (1 << `HEAP_INDEX_BITS)

// ---------------------------------------
// Modify codes
// ---------------------------------------
// Opcode sits in the low bits of the request data, operand in the bits above
`define HEAP_OP_BITS 3
`define HEAP_OP_ADD  3'd0                     // Element + operand
`define HEAP_OP_SUB  3'd1                     // Element - operand
`define HEAP_OP_OR   3'd2
`define HEAP_OP_XOR  3'd3
`define HEAP_OP_AND  3'd4

`endif

//--- list.f
+incdir+include
src/heapPkg.sv
src/elementStore.sv
src/sizeTable.sv
src/arrayAllocator.sv
src/heapSequencer.sv
src/arrayHeap.sv
verif/heap_properties.sv
verif/heapTb.sv

//--- src/arrayAllocator.sv
//----------------------------------------
// Array allocator
// Allocation flags, stack of freed arrays, fresh counter
//----------------------------------------
`include "heap_defines.svh"

module arrayAllocator (
  input  logic                          clock,
  input  logic                          resetN,
  input  logic                          allocate,
  input  logic                          deallocate,
  input  logic                          clearAll,
  input  logic [`HEAP_ADDRESS_BITS-1:0] array,
  output logic                          isAllocated,
  output logic [`HEAP_ADDRESS_BITS-1:0] freeArray,
  output logic                          haveFree
);

  logic [`HEAP_ARRAYS-1:0]       flags;        // One per array
  logic [`HEAP_ADDRESS_BITS-1:0] freeStack [`HEAP_ARRAYS];
  logic [`HEAP_ADDRESS_BITS:0]   stackTop;     // Count of freed arrays
  logic [`HEAP_ADDRESS_BITS:0]   stackBelow;
  logic [`HEAP_ADDRESS_BITS:0]   freshCount;   // Arrays never handed out yet

  assign stackBelow  = stackTop - 1'b1;
  assign isAllocated = flags[array];
  assign haveFree    = stackTop != '0 || freshCount != `HEAP_ARRAYS;
  assign freeArray   = stackTop != '0 ? freeStack[stackBelow[`HEAP_ADDRESS_BITS-1:0]]
                                      : freshCount[`HEAP_ADDRESS_BITS-1:0];  // Reuse first

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      flags      <= '0;
      stackTop   <= '0;
      freshCount <= '0;
    end else if (clearAll) begin
      flags      <= '0;                          // Everything unallocated
      stackTop   <= '0;
      freshCount <= '0;
    end else if (allocate) begin
      flags[freeArray] <= 1'b1;
      if (stackTop != '0) begin
        stackTop <= stackBelow;                  // Pop freed array
      end else begin
        freshCount <= freshCount + 1'b1;
      end
    end else if (deallocate) begin
      flags[array] <= 1'b0;                      // Flag of the freed array
      stackTop     <= stackTop + 1'b1;
    end
  end

  // Stack slots, only meaningful below stackTop
  always_ff @(posedge clock) begin
    if (deallocate) freeStack[stackTop[`HEAP_ADDRESS_BITS-1:0]] <= array;
  end

endmodule

//--- src/arrayHeap.sv
//----------------------------------------
// Array heap top level
// Sequencer plus allocator, size table and element memory
//----------------------------------------
`include "heap_defines.svh"

module arrayHeap (
  input  logic              clock,
  input  logic              resetN,
  input  logic              start,            // One-cycle command strobe
  input  heapPkg::requestT  request,
  output logic              done,             // Pulse 3 cycles after start
  output heapPkg::responseT response
);
  import heapPkg::*;

  logic                          allocate;
  logic                          deallocate;
  logic                          clearAll;    // Reset action
  logic [`HEAP_ADDRESS_BITS-1:0] allocArray;  // Latched array number
  logic                          isAllocated;
  logic [`HEAP_ADDRESS_BITS-1:0] freeArray;   // Next array Alloc hands out
  logic                          haveFree;
  logic                          sizeWrite;
  logic [`HEAP_INDEX_BITS:0]     newSize;
  logic [`HEAP_INDEX_BITS:0]     currentSize;
  elementOpT                     elementOp;
  logic [`HEAP_DATA_BITS-1:0]    readData;
  logic [`HEAP_DATA_BITS-1:0]    resultData;  // Modified element value

  heapSequencer sequencer (
    .clock       (clock),
    .resetN      (resetN),
    .start       (start),
    .request     (request),
    .isAllocated (isAllocated),
    .haveFree    (haveFree),
    .freeArray   (freeArray),
    .currentSize (currentSize),
    .readData    (readData),
    .resultData  (resultData),
    .allocate    (allocate),
    .deallocate  (deallocate),
    .clearAll    (clearAll),
    .allocArray  (allocArray),
    .sizeWrite   (sizeWrite),
    .newSize     (newSize),
    .elementOp   (elementOp),
    .done        (done),
    .response    (response)
  );

  arrayAllocator allocator (
    .clock       (clock),
    .resetN      (resetN),
    .allocate    (allocate),
    .deallocate  (deallocate),
    .clearAll    (clearAll),
    .array       (allocArray),
    .isAllocated (isAllocated),
    .freeArray   (freeArray),
    .haveFree    (haveFree)
  );

  sizeTable sizes (
    .clock       (clock),
    .resetN      (resetN),
    .clearAll    (clearAll),
    .sizeWrite   (sizeWrite),
    .array       (allocArray),                // Same latched array
    .newSize     (newSize),
    .currentSize (currentSize)
  );

  elementStore store (
    .clock      (clock),
    .elementOp  (elementOp),
    .readData   (readData),
    .resultData (resultData)
  );

endmodule

//--- src/elementStore.sv
//----------------------------------------
// Element store
// Registered-read element memory with Modify arithmetic
//----------------------------------------
`include "heap_defines.svh"

module elementStore (
  input  logic                       clock,
  input  heapPkg::elementOpT         elementOp,
  output logic [`HEAP_DATA_BITS-1:0] readData,    // One cycle after address
  output logic [`HEAP_DATA_BITS-1:0] resultData   // Modified readData
);

  logic [`HEAP_DATA_BITS-1:0] memory [`HEAP_ARRAYS * `HEAP_ARRAY_LENGTH];
  logic [`HEAP_ADDRESS_BITS+`HEAP_INDEX_BITS-1:0] address;

  assign address = {elementOp.array, elementOp.index};  // Fixed block per array

  // ---------------------------------------
  // Memory port
  // ---------------------------------------
  always_ff @(posedge clock) begin
    if (elementOp.writeEnable) begin
      memory[address] <= elementOp.data;
    end else if (elementOp.modifyEnable) begin
      memory[address] <= resultData;             // Write back a cycle after read
    end
    readData <= memory[address];                 // Old value on same-edge write
  end

  // ---------------------------------------
  // Modify unit
  // ---------------------------------------
  always_comb begin
    case (elementOp.opcode)
      `HEAP_OP_ADD: resultData = readData + elementOp.data;   // Wraps at 12 bits
      `HEAP_OP_SUB: resultData = readData - elementOp.data;
      `HEAP_OP_OR:  resultData = readData | elementOp.data;
      `HEAP_OP_XOR: resultData = readData ^ elementOp.data;
      `HEAP_OP_AND: resultData = readData & elementOp.data;
      default:      resultData = readData;       // Unknown code leaves value
    endcase
  end

endmodule

//--- src/heapPkg.sv
//----------------------------------------
// Heap package
// Command, result and element access types
//----------------------------------------
`include "heap_defines.svh"

package heapPkg;

  typedef enum logic [3:0] {
    actReset  = 4'd1,                         // Free every array
    actWrite  = 4'd2,                         // Write element, may grow size
    actRead   = 4'd3,                         // Read element below size
    actSize   = 4'd4,                         // Current element count
    actPush   = 4'd5,                         // Append at size
    actPop    = 4'd6,                         // Remove last element
    actAlloc  = 4'd7,                         // Returns new array number
    actFree   = 4'd8,                         // Release array for reuse
    actModify = 4'd9                          // Arithmetic on one element
  } actionT;

  typedef enum logic [2:0] {
    errNone         = 3'd0,
    errNotAllocated = 3'd1,                   // Also a second Free
    errOutOfBounds  = 3'd2,                   // Index at or beyond size
    errFull         = 3'd3,                   // Push to full array
    errEmpty        = 3'd4,                   // Pop from empty array
    errOutOfMemory  = 3'd5                    // Alloc with no array left
  } errorT;

  typedef struct packed {
    actionT                         action;
    logic [`HEAP_ADDRESS_BITS-1:0] array;
    logic [`HEAP_INDEX_BITS-1:0]   index;
    logic [`HEAP_DATA_BITS-1:0]    data;     // Value, or opcode plus operand
  } requestT;

  typedef struct packed {
    logic [`HEAP_DATA_BITS-1:0] data;
    errorT                      error;
  } responseT;

  typedef struct packed {
    logic                           writeEnable;  // Plain write of data
    logic                           modifyEnable; // Write back modified value
    logic [`HEAP_OP_BITS-1:0]       opcode;
    logic [`HEAP_ADDRESS_BITS-1:0] array;
    logic [`HEAP_INDEX_BITS-1:0]   index;
    logic [`HEAP_DATA_BITS-1:0]    data;         // Write value or operand
  } elementOpT;

endpackage

//--- src/heapSequencer.sv
//----------------------------------------
// Heap command sequencer
// Idle, check, access, respond for every command
// Decides the error and steers the storage blocks
//----------------------------------------
`include "heap_defines.svh"

module heapSequencer (
  input  logic                          clock,
  input  logic                          resetN,
  input  logic                          start,
  input  heapPkg::requestT              request,
  input  logic                          isAllocated,
  input  logic                          haveFree,
  input  logic [`HEAP_ADDRESS_BITS-1:0] freeArray,
  input  logic [`HEAP_INDEX_BITS:0]     currentSize,
  input  logic [`HEAP_DATA_BITS-1:0]    readData,
  input  logic [`HEAP_DATA_BITS-1:0]    resultData,
  output logic                          allocate,
  output logic                          deallocate,
  output logic                          clearAll,
  output logic [`HEAP_ADDRESS_BITS-1:0] allocArray,
  output logic                          sizeWrite,
  output logic [`HEAP_INDEX_BITS:0]     newSize,
  output heapPkg::elementOpT            elementOp,
  output logic                          done,
  output heapPkg::responseT             response
);
  import heapPkg::*;

  typedef enum logic [1:0] {stIdle, stCheck, stAccess, stRespond} stateT;

  stateT                      state;
  requestT                    held;           // Command being served
  errorT                      checkError;
  errorT                      heldError;
  logic                       accept;
  logic                       accessing;
  logic                       responding;
  logic                       ok;
  logic [`HEAP_INDEX_BITS:0]  indexPlusOne;
  logic [`HEAP_INDEX_BITS:0]  sizeLessOne;
  logic [`HEAP_DATA_BITS-1:0] answer;

  assign accept       = start && state == stIdle;  // Busy starts are dropped
  assign accessing    = state == stAccess;
  assign responding   = state == stRespond;
  assign ok           = heldError == errNone;
  assign indexPlusOne = {1'b0, held.index} + 1'b1;
  assign sizeLessOne  = currentSize - 1'b1;

  // ---------------------------------------
  // State and request latch
  // ---------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      state <= stIdle;
    end else begin
      case (state)
        stIdle:   if (accept) state <= stCheck;
        stCheck:  state <= stAccess;
        stAccess: state <= stRespond;
        default:  state <= stIdle;                 // Respond lasts one cycle
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (accept) held <= request;
  end

  // ---------------------------------------
  // Error decision, used in check
  // ---------------------------------------
  always_comb begin
    checkError = errNone;
    case (held.action)
      actReset: checkError = errNone;
      actAlloc: if (!haveFree) checkError = errOutOfMemory;
      default: begin
        if (!isAllocated) begin
          checkError = errNotAllocated;          // Never allocated or freed
        end else if ((held.action == actRead || held.action == actModify) &&
                     {1'b0, held.index} >= currentSize) begin
          checkError = errOutOfBounds;
        end else if (held.action == actPush && currentSize == `HEAP_ARRAY_LENGTH) begin
          checkError = errFull;
        end else if (held.action == actPop && currentSize == '0) begin
          checkError = errEmpty;
        end
      end
    endcase
  end

  // ---------------------------------------
  // Allocator and size updates, land on leaving respond
  // ---------------------------------------
  assign allocate   = responding && ok && held.action == actAlloc;
  assign deallocate = responding && ok && held.action == actFree;
  assign clearAll   = responding && held.action == actReset;
  assign allocArray = held.array;
  assign sizeWrite  = responding && ok && (held.action == actWrite || held.action == actPush ||
                                           held.action == actPop || held.action == actFree);

  always_comb begin
    newSize = '0;                                // Free empties the array
    case (held.action)
      actWrite: newSize = indexPlusOne > currentSize ? indexPlusOne : currentSize;
      actPush:  newSize = currentSize + 1'b1;
      actPop:   newSize = sizeLessOne;
      default:  newSize = '0;
    endcase
  end

  // ---------------------------------------
  // Element access
  // ---------------------------------------
  always_comb begin
    elementOp.writeEnable  = accessing && ok &&
                             (held.action == actWrite || held.action == actPush);
    elementOp.modifyEnable = responding && ok && held.action == actModify;  // Write back
    elementOp.opcode       = held.data[`HEAP_OP_BITS-1:0];
    elementOp.array        = held.array;
    elementOp.index        = held.index;
    elementOp.data         = held.data;
    case (held.action)
      actPush:   elementOp.index = currentSize[`HEAP_INDEX_BITS-1:0];  // Next free slot
      actPop:    elementOp.index = sizeLessOne[`HEAP_INDEX_BITS-1:0];  // Last element
      actModify: elementOp.data  = held.data >> `HEAP_OP_BITS;         // Operand above code
      default:   elementOp.data  = held.data;
    endcase
  end

  // Response data before the storage updates
  always_comb begin
    answer = '0;
    case (held.action)
      actWrite, actPush: answer = held.data;
      actRead, actPop:   answer = readData;
      actModify:         answer = resultData;    // New element value
      actSize:           answer[`HEAP_INDEX_BITS:0] = currentSize;
      actAlloc:          answer[`HEAP_ADDRESS_BITS-1:0] = freeArray;
      default:           answer = '0;
    endcase
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      heldError <= errNone;
      done      <= 1'b0;
      response  <= '0;
    end else begin
      done <= responding;                        // Single pulse
      if (state == stCheck) heldError <= checkError;
      if (responding) begin
        response.data  <= ok ? answer : '0;      // Zero data on error
        response.error <= heldError;
      end
    end
  end

endmodule

//--- src/sizeTable.sv
//----------------------------------------
// Size table
// Element count of every array
//----------------------------------------
`include "heap_defines.svh"

module sizeTable (
  input  logic                          clock,
  input  logic                          resetN,
  input  logic                          clearAll,
  input  logic                          sizeWrite,
  input  logic [`HEAP_ADDRESS_BITS-1:0] array,
  input  logic [`HEAP_INDEX_BITS:0]     newSize,
  output logic [`HEAP_INDEX_BITS:0]     currentSize
);

  logic [`HEAP_ARRAYS-1:0][`HEAP_INDEX_BITS:0] sizes;  // 0 to full length

  assign currentSize = sizes[array];             // Combinational lookup

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      sizes <= '0;
    end else if (clearAll) begin
      sizes <= '0;
    end else if (sizeWrite) begin
      sizes[array] <= newSize;
    end
  end

endmodule

//--- verif/heapTb.sv
//----------------------------------------
// Heap testbench
// Directed and random commands against a reference model
//----------------------------------------
`include "heap_defines.svh"

module heapTb;
  timeunit 1ns;
  timeprecision 1ps;
  import heapPkg::*;

  logic     clock = 1'b0;
  logic     resetN;
  logic     start;
  requestT  request;
  logic     done;
  responseT response;

  // Reference model state
  logic [`HEAP_DATA_BITS-1:0] memory [`HEAP_ARRAYS * `HEAP_ARRAY_LENGTH];
  bit flags [`HEAP_ARRAYS];
  int sizes [`HEAP_ARRAYS];
  int freed [$];                              // Free stack, top at the back
  int fresh = 0;                              // Next never used array

  arrayHeap dut_i (
    .clock    (clock),
    .resetN   (resetN),
    .start    (start),
    .request  (request),
    .done     (done),
    .response (response)
  );

  always #10 clock = ~clock;                  // 20 ns period

  task automatic stopWithFailure(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic valueError(input string name, input int expected, input int actual);
    stopWithFailure($sformatf("ERR %0t %s expected %0h got %0h", $time, name, expected, actual));
  endtask

  // Fill value built from the whole element address
  function automatic int fillValue(input int array, input int index);
    return int'({array[2:0], index[2:0], ~array[2:0], ~index[2:0]});
  endfunction

  // ---------------------------------------
  // Reference model, one command
  // ---------------------------------------
  task automatic predict(input requestT r, output logic [`HEAP_DATA_BITS-1:0] expData,
                         output errorT expErr);
    int a;
    int i;
    int s;
    int slot;
    logic [`HEAP_DATA_BITS-1:0] operand;
    logic [`HEAP_DATA_BITS-1:0] value;
    a       = int'(r.array);
    i       = int'(r.index);
    s       = sizes[a];
    slot    = a * `HEAP_ARRAY_LENGTH + i;
    operand = r.data >> `HEAP_OP_BITS;        // Code in the low bits
    expData = '0;                             // No data on error
    expErr  = errNone;
    if (r.action == actReset) begin
      foreach (flags[k]) begin
        flags[k] = 1'b0;
        sizes[k] = 0;
      end
      freed.delete();
      fresh = 0;
    end else if (r.action == actAlloc) begin
      if (freed.size() == 0 && fresh == `HEAP_ARRAYS) begin
        expErr = errOutOfMemory;
      end else begin
        if (freed.size() != 0) begin
          a = freed.pop_back();               // Last freed goes first
        end else begin
          a = fresh;
          fresh++;
        end
        flags[a] = 1'b1;
        expData  = a[`HEAP_DATA_BITS-1:0];
      end
    end else if (!flags[a]) begin
      expErr = errNotAllocated;
    end else begin
      case (r.action)
        actWrite: begin
          memory[slot] = r.data;
          if (i + 1 > s) sizes[a] = i + 1;    // Grows to highest index + 1
          expData = r.data;
        end
        actRead: begin
          if (i >= s) expErr = errOutOfBounds;
          else expData = memory[slot];
        end
        actSize: expData = s[`HEAP_DATA_BITS-1:0];
        actPush: begin
          if (s == `HEAP_ARRAY_LENGTH) begin
            expErr = errFull;
          end else begin
            memory[a * `HEAP_ARRAY_LENGTH + s] = r.data;
            sizes[a] = s + 1;
            expData  = r.data;
          end
        end
        actPop: begin
          if (s == 0) begin
            expErr = errEmpty;
          end else begin
            sizes[a] = s - 1;
            expData  = memory[a * `HEAP_ARRAY_LENGTH + s - 1];
          end
        end
        actFree: begin
          flags[a] = 1'b0;
          sizes[a] = 0;
          freed.push_back(a);
        end
        default: begin                        // Modify
          if (i >= s) begin
            expErr = errOutOfBounds;
          end else begin
            value = memory[slot];
            case (r.data[`HEAP_OP_BITS-1:0])
              `HEAP_OP_ADD: value = value + operand;
              `HEAP_OP_SUB: value = value - operand;
              `HEAP_OP_OR:  value = value | operand;
              `HEAP_OP_XOR: value = value ^ operand;
              `HEAP_OP_AND: value = value & operand;
              default:      value = value;
            endcase
            memory[slot] = value;
            expData      = value;
          end
        end
      endcase
    end
  endtask

  // ---------------------------------------
  // One command through the DUT
  // ---------------------------------------
  task automatic run(input actionT action, input int array, input int index, input int data,
                     input bit busyStrobe);
    requestT                    req;
    requestT                    junk;
    logic [`HEAP_DATA_BITS-1:0] expData;
    errorT                      expErr;
    int                         cycles;
    req.action = action;
    req.array  = array[`HEAP_ADDRESS_BITS-1:0];
    req.index  = index[`HEAP_INDEX_BITS-1:0];
    req.data   = data[`HEAP_DATA_BITS-1:0];
    junk       = req;
    junk.action = actReset;                   // Would clear everything if accepted
    predict(req, expData, expErr);
    @(posedge clock);
    start   <= 1'b1;
    request <= req;
    cycles  = 0;
    do begin
      @(posedge clock);
      cycles++;                               // First edge samples start
      if (busyStrobe && cycles == 1) begin
        request <= junk;                      // Start held into check
      end else begin
        start <= 1'b0;
      end
      @(negedge clock);
    end while (!done && cycles < 20);
    if (!done) stopWithFailure("no done within 20 cycles of start");
    assert (cycles - 1 == 3)
      else stopWithFailure($sformatf("done came %0d cycles after start", cycles - 1));
    assert (response.error == expErr)
      else valueError("response.error", expErr, response.error);
    assert (response.data == expData)
      else valueError("response.data", expData, response.data);
    assert (dut_i.timingChecks.failures == 0)
      else stopWithFailure("a timing assertion on the DUT ports failed");
  endtask

  task automatic randomRun(input int count);
    int     n;
    int     pick;
    int     data;
    actionT action;
    for (n = 0; n < count; n++) begin
      pick = $urandom_range(99);
      data = $urandom_range(4095);
      if (pick < 2) action = actReset;        // Rare, empties the heap
      else if (pick < 12) action = actAlloc;
      else if (pick < 18) action = actFree;
      else if (pick < 32) action = actWrite;
      else if (pick < 46) action = actRead;
      else if (pick < 54) action = actSize;
      else if (pick < 68) action = actPush;
      else if (pick < 82) action = actPop;
      else action = actModify;
      if (action == actModify) data = ($urandom_range(511) << 3) | $urandom_range(4);
      run(action, $urandom_range(7), $urandom_range(7), data, pick % 17 == 0);
    end
  endtask

  // ---------------------------------------
  // Stimulus
  // ---------------------------------------
  initial begin
    int a;
    int i;
    void'($urandom(11));
    resetN  = 1'b0;
    start   = 1'b0;
    request = '0;
    repeat (10) @(posedge clock);
    resetN <= 1'b1;
    for (a = 0; a < 9; a++) run(actAlloc, 0, 0, 0, 1'b0);  // Counting order, then no memory
    for (a = 0; a < 8; a++) begin
      for (i = 0; i < 8; i++) run(actWrite, a, i, fillValue(a, i), 1'b0);
    end
    run(actFree, 3, 0, 0, 1'b0);
    run(actFree, 5, 0, 0, 1'b0);
    run(actAlloc, 0, 0, 0, 1'b0);             // Gets 5 back
    run(actAlloc, 0, 0, 0, 1'b0);
    run(actFree, 3, 0, 0, 1'b0);
    run(actFree, 3, 0, 0, 1'b0);              // Double free
    run(actRead, 3, 0, 0, 1'b0);
    run(actReset, 0, 0, 0, 1'b0);
    run(actSize, 0, 0, 0, 1'b0);
    run(actWrite, 2, 1, 5, 1'b0);
    run(actAlloc, 0, 0, 0, 1'b0);
    run(actWrite, 0, 4, 'h5A5, 1'b0);
    run(actSize, 0, 0, 0, 1'b0);
    run(actRead, 0, 4, 0, 1'b0);
    run(actRead, 0, 5, 0, 1'b0);              // At size
    run(actRead, 0, 1, 0, 1'b0);              // Old fill value
    for (i = 0; i < 4; i++) run(actPush, 0, 0, 'h100 + i, 1'b0);
    for (i = 0; i < 9; i++) run(actPop, 0, 0, 0, 1'b0);
    run(actWrite, 0, 0, 'hFF0, 1'b0);
    for (i = 0; i < 5; i++) run(actModify, 0, 0, 'hAA8 | i, 1'b0);
    run(actRead, 0, 0, 0, 1'b0);
    run(actModify, 0, 3, 'hAA8, 1'b0);        // Beyond size 1
    run(actSize, 0, 0, 0, 1'b1);              // Second strobe while busy
    randomRun(400);
    repeat (2) @(posedge clock);              // Last done pulse ends its properties
    @(negedge clock);
    if (dut_i.timingChecks.failures == 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      stopWithFailure("a timing assertion on the DUT ports failed");
    end
  end

endmodule

//--- verif/heap_properties.sv
//----------------------------------------
// Heap port timing properties
// Done latency, pulse width and reset level
//----------------------------------------
module heapProperties (
  input logic clock,
  input logic resetN,
  input logic start,
  input logic done
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [1:0]  phase;                         // 0 idle, then check, access, respond
  logic        accepted;
  int unsigned failures = 0;                  // Read by the testbench

  assign accepted = start && phase == 2'd0;   // Starts while busy are dropped

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      phase <= 2'd0;
    end else if (phase != 2'd0) begin
      phase <= phase + 2'd1;                  // Respond wraps back to idle
    end else if (start) begin
      phase <= 2'd1;
    end
  end

  // ---------------------------------------
  // Done timing
  // ---------------------------------------
  property doneAfterThree;
    @(posedge clock) disable iff (!resetN)
      accepted |-> ##1 !done ##1 !done ##1 !done ##1 done;
  endproperty

  property doneSingleCycle;
    @(posedge clock) disable iff (!resetN)
      done |=> !done;
  endproperty

  property doneOnlyAfterRespond;
    @(posedge clock) disable iff (!resetN)
      done |-> $past(phase) == 2'd3;
  endproperty

  property doneLowInReset;
    @(posedge clock) !resetN |-> !done;
  endproperty

  assert property (doneAfterThree) else begin
    $error("done did not rise 3 cycles after an accepted start");
    failures++;
  end

  assert property (doneSingleCycle) else begin
    $error("done stayed high for more than one cycle");
    failures++;
  end

  assert property (doneOnlyAfterRespond) else begin
    $error("done rose without a command in respond");
    failures++;
  end

  assert property (doneLowInReset) else begin
    $error("done high during reset");
    failures++;
  end

endmodule

bind arrayHeap heapProperties timingChecks (
  .clock  (clock),
  .resetN (resetN),
  .start  (start),
  .done   (done)
);
